/* hw/decodePkg.sv */
`default_nettype none

package decodePkg;

    ////////////////////
    // encodings
    ////////////////////

    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opBlez    = 6'h06,
        opBgtz    = 6'h07,
        opAddi    = 6'h08,
        opAddiu   = 6'h09,
        opSlti    = 6'h0a,
        opSltiu   = 6'h0b,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opXori    = 6'h0e,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    // r-type function, bits 5:0
    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnSrl  = 6'h02,
        fnSra  = 6'h03,
        fnJr   = 6'h08,
        fnJalr = 6'h09,
        fnAdd  = 6'h20,
        fnAddu = 6'h21,
        fnSub  = 6'h22,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnNor  = 6'h27,
        fnSlt  = 6'h2a,
        fnSltu = 6'h2b
    } functT;

    typedef enum logic [3:0] {
        aluAdd, aluAddu, aluSub, aluSubu, aluAnd, aluOr, aluXor,
        aluNor, aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
    } aluOpT;

    // write-back register select
    typedef enum logic [1:0] {
        dstRt = 2'd0,
        dstRd = 2'd1,
        dstRa = 2'd2
    } regDstT;

    ////////////////////
    // bundles
    ////////////////////

    typedef struct packed {
        logic   regWrite;
        aluOpT  aluOp;
        logic   aluSrc;    // second alu operand is the immediate
        regDstT regDst;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   branch;    // branch taken, already resolved
        logic   jump;      // j or jal
        logic   jumpReg;   // jr or jalr
        logic   link;      // pc+4 goes to the destination
        logic   illegal;
    } ctrlT;

    typedef struct packed {
        logic        enable;
        logic [4:0]  addr;
        logic [31:0] data;
    } regWriteT;

    typedef struct packed {
        logic [31:0] readData1;
        logic [31:0] readData2;
        logic [31:0] pcPlus4;
        logic [31:0] signExtImm;
        logic [31:0] branchTarget;
        logic [31:0] jumpTarget;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } decodeOutT;

    // rs against rt, lt and gt signed
    typedef struct packed {
        logic eq;
        logic lt;
        logic gt;
        logic zero;
    } cmpFlagsT;

endpackage

`default_nettype wire

/* hw/registerFile.sv */
`timescale 1ns/100ps
`default_nettype none

module registerFile #(
    parameter bit writeBypass = 1'b1
) (
    input  logic                Clk,
    input  logic                rstN,
    input  logic [4:0]          readAddr1,
    input  logic [4:0]          readAddr2,
    input  decodePkg::regWriteT wb,
    output logic [31:0]         readData1,
    output logic [31:0]         readData2
);
    import decodePkg::*;

    // $0 not stored
    logic [31:0] regs [1:31];

    ////////////////////
    // write port
    ////////////////////

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.enable && (wb.addr != 5'd0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    // same lookup for both ports
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        logic [31:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (writeBypass && wb.enable && (wb.addr == addr)) begin
            // write in flight this cycle
            value = wb.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        readData1 = readPort(readAddr1);
        readData2 = readPort(readAddr2);
    end

endmodule

`default_nettype wire

/* hw/decodeController.sv */
`timescale 1ns/100ps
`default_nettype none

module decodeController (
    input  decodePkg::opcodeT opcode,
    input  decodePkg::functT  funct,
    input  logic [4:0]        rtField,
    input  logic [31:0]       rsData,
    input  logic [31:0]       rtData,
    output decodePkg::ctrlT   ctrl
);
    import decodePkg::*;

    cmpFlagsT flags;

    ////////////////////
    // operand compare
    ////////////////////

    always_comb begin
        flags.eq   = (rsData == rtData);
        flags.lt   = ($signed(rsData) < $signed(rtData));
        flags.gt   = ($signed(rsData) > $signed(rtData));
        flags.zero = (rsData == 32'd0);
    end

    ////////////////////
    // main decode
    ////////////////////

    always_comb begin
        // nop-like defaults, every field driven
        ctrl        = '0;
        ctrl.aluOp  = aluAdd;
        ctrl.regDst = dstRt;

        case (opcode)
            opSpecial: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstRd;
                case (funct)
                    fnAdd:  ctrl.aluOp = aluAdd;
                    fnAddu: ctrl.aluOp = aluAddu;
                    fnSub:  ctrl.aluOp = aluSub;
                    fnSubu: ctrl.aluOp = aluSubu;
                    fnAnd:  ctrl.aluOp = aluAnd;
                    fnOr:   ctrl.aluOp = aluOr;
                    fnXor:  ctrl.aluOp = aluXor;
                    fnNor:  ctrl.aluOp = aluNor;
                    fnSlt:  ctrl.aluOp = aluSlt;
                    fnSltu: ctrl.aluOp = aluSltu;
                    fnSll:  ctrl.aluOp = aluSll;
                    fnSrl:  ctrl.aluOp = aluSrl;
                    fnSra:  ctrl.aluOp = aluSra;
                    fnJr: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.jumpReg  = 1'b1;
                    end
                    fnJalr: begin
                        // return address into rd
                        ctrl.jumpReg = 1'b1;
                        ctrl.link    = 1'b1;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end

            // immediate alu group, always rt destination
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                case (opcode)
                    opAddiu: ctrl.aluOp = aluAddu;
                    opSlti:  ctrl.aluOp = aluSlt;
                    opSltiu: ctrl.aluOp = aluSltu;
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    opLui:   ctrl.aluOp = aluLui;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end

            opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end

            // branches resolved here, no alu involvement
            opBeq: ctrl.branch = flags.eq;
            opBne: ctrl.branch = !flags.eq;
            // rt must be $0, so rtData is 0 and lt/gt compare rs against zero
            opBlez: begin
                ctrl.branch  = flags.zero | flags.lt;
                ctrl.illegal = (rtField != 5'd0);
            end
            opBgtz: begin
                ctrl.branch  = flags.gt;
                ctrl.illegal = (rtField != 5'd0);
            end

            opJ: ctrl.jump = 1'b1;
            opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstRa;
            end

            default: ctrl.illegal = 1'b1;
        endcase

        // squash side effects of anything not decoded
        if (ctrl.illegal) begin
            ctrl.regWrite = 1'b0;
            ctrl.memRead  = 1'b0;
            ctrl.memWrite = 1'b0;
            ctrl.branch   = 1'b0;
            ctrl.jump     = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/instructionDecodeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module instructionDecodeStage #(
    parameter bit writeBypass = 1'b1
) (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic [31:0]          instr,
    input  logic [31:0]          pcPlus4,
    input  decodePkg::regWriteT  wb,
    output decodePkg::ctrlT      ctrl,
    output decodePkg::decodeOutT dec
);
    import decodePkg::*;

    ////////////////////
    // field extraction
    ////////////////////

    logic [4:0]  rsField;
    logic [4:0]  rtField;
    logic [15:0] immField;
    logic [25:0] jumpIndex;
    logic [31:0] readData1;
    logic [31:0] readData2;
    logic [31:0] signExtImm;

    assign rsField   = instr[25:21];
    assign rtField   = instr[20:16];
    assign immField  = instr[15:0];
    assign jumpIndex = instr[25:0];

    // always sign-extended, execute picks the use
    assign signExtImm = {{16{immField[15]}}, immField};

    ////////////////////
    // submodules
    ////////////////////

    registerFile #(
        .writeBypass(writeBypass)
    ) registerFile_i (
        .Clk       (Clk),
        .rstN      (rstN),
        .readAddr1 (rsField),
        .readAddr2 (rtField),
        .wb        (wb),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    // raw bits cast onto the enums, unknown codes fall to default
    decodeController decodeController_i (
        .opcode  (opcodeT'(instr[31:26])),
        .funct   (functT'(instr[5:0])),
        .rtField (rtField),
        .rsData  (readData1),
        .rtData  (readData2),
        .ctrl    (ctrl)
    );

    ////////////////////
    // outputs
    ////////////////////

    always_comb begin
        dec.readData1    = readData1;
        dec.readData2    = readData2;
        dec.pcPlus4      = pcPlus4;
        dec.signExtImm   = signExtImm;
        // word offset relative to the delay slot pc
        dec.branchTarget = pcPlus4 + {signExtImm[29:0], 2'b00};
        // region bits kept from pc+4
        dec.jumpTarget   = {pcPlus4[31:28], jumpIndex, 2'b00};
        dec.rt           = rtField;
        dec.rd           = instr[15:11];
        dec.shamt        = instr[10:6];
        dec.funct        = instr[5:0];
    end

endmodule

`default_nettype wire

/* dv/decodeStageAsserts.sv */
`timescale 1ns/100ps
`default_nettype none

module decodeStageAsserts (
    input logic                 Clk,
    input logic                 rstN,
    input logic [31:0]          instr,
    input decodePkg::ctrlT      ctrl,
    input decodePkg::decodeOutT dec
);
    import decodePkg::*;

    cmpFlagsT flags;
    logic     isBranch;
    logic     takenExpected;

    // rs against rt from the decoded operands
    always_comb begin
        flags.eq   = (dec.readData1 == dec.readData2);
        flags.lt   = ($signed(dec.readData1) < $signed(dec.readData2));
        flags.gt   = ($signed(dec.readData1) > $signed(dec.readData2));
        flags.zero = (dec.readData1 == 32'd0);
    end

    // taken decision per branch opcode
    always_comb begin
        isBranch      = 1'b1;
        takenExpected = 1'b0;
        case (instr[31:26])
            6'h04: takenExpected = flags.eq;
            6'h05: takenExpected = !flags.eq;
            // only legal with rt = $0, then lt and gt compare rs against zero
            6'h06: takenExpected = (instr[20:16] == 5'd0) && (flags.zero || flags.lt);
            6'h07: takenExpected = (instr[20:16] == 5'd0) && flags.gt;
            default: isBranch = 1'b0;
        endcase
    end

    ////////////////////
    // properties
    ////////////////////

    // $0 through port 1
    rsZeroReadsZero: assert property (@(posedge Clk) disable iff (!rstN)
        (instr[25:21] == 5'd0) |-> (dec.readData1 == 32'd0))
        else $error("readData1 nonzero while rs is register 0");

    noLoadAndStore: assert property (@(posedge Clk) disable iff (!rstN)
        !(ctrl.memRead && ctrl.memWrite))
        else $error("memRead and memWrite set together");

    noBranchAndJump: assert property (@(posedge Clk) disable iff (!rstN)
        !(ctrl.branch && ctrl.jump))
        else $error("branch and jump set together");

    // undecoded instructions must not touch state
    illegalIsQuiet: assert property (@(posedge Clk) disable iff (!rstN)
        ctrl.illegal |-> (!ctrl.regWrite && !ctrl.memWrite))
        else $error("illegal instruction with regWrite or memWrite set");

    // beq, bne, blez and bgtz taken exactly per the compare flags
    branchFollowsFlags: assert property (@(posedge Clk) disable iff (!rstN)
        isBranch |-> (ctrl.branch == takenExpected))
        else $error("branch decision differs from operand compare");

endmodule

bind instructionDecodeStage decodeStageAsserts decodeStageAsserts_i (
    .Clk  (Clk),
    .rstN (rstN),
    .instr(instr),
    .ctrl (ctrl),
    .dec  (dec)
);

`default_nettype wire

/* dv/tbDecodeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module tbDecodeStage;
    import decodePkg::*;

    localparam int clkPeriod = 10;

    logic        Clk;
    logic        rstN;
    logic [31:0] instr;
    logic [31:0] pcPlus4;
    regWriteT    wb;
    ctrlT        ctrl;
    decodeOutT   dec;

    // reference copy of the architectural registers
    logic [31:0] model [0:31];
    int          cycleCount;
    int          errorCount;
    int          checkCount;
    bit          timedOut;

    instructionDecodeStage #(
        .writeBypass(1'b1)
    ) instructionDecodeStage_i (
        .Clk    (Clk),
        .rstN   (rstN),
        .instr  (instr),
        .pcPlus4(pcPlus4),
        .wb     (wb),
        .ctrl   (ctrl),
        .dec    (dec)
    );

    always #(clkPeriod / 2) Clk = ~Clk;

    // edge counter, updated in the nba region
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
    end

    ////////////////////
    // timing helpers
    ////////////////////

    // returns 1 ns after the n-th rising edge
    task automatic waitCycles(input int n);
        int target;
        int spins;
        target = cycleCount + n;
        spins = 0;
        while (!timedOut && cycleCount < target) begin
            #1;
            spins++;
            if (spins > (n + 1) * clkPeriod) begin
                $display("timeout after %0d ns waiting for %0d clock edges", spins, n);
                timedOut = 1'b1;
            end
        end
    endtask

    // combinational outputs settle well before the next edge
    task automatic settle();
        #2;
    endtask

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkCtrl(input string name, input ctrlT expected, input ctrlT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkDec(input string name, input decodeOutT expected,
                            input decodeOutT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    ////////////////////
    // instruction builders and expected values
    ////////////////////

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // control table in mips encodings
    function automatic ctrlT expectedCtrl(input logic [31:0] word, input logic [31:0] rsVal,
                                          input logic [31:0] rtVal);
        ctrlT c;
        logic [5:0] op;
        logic [5:0] fn;
        op = word[31:26];
        fn = word[5:0];
        c = '0;
        c.aluOp = aluAdd;
        c.regDst = dstRt;
        case (op)
            6'h00: begin
                c.regWrite = 1'b1;
                c.regDst = dstRd;
                case (fn)
                    6'h20: c.aluOp = aluAdd;
                    6'h21: c.aluOp = aluAddu;
                    6'h22: c.aluOp = aluSub;
                    6'h23: c.aluOp = aluSubu;
                    6'h24: c.aluOp = aluAnd;
                    6'h25: c.aluOp = aluOr;
                    6'h26: c.aluOp = aluXor;
                    6'h27: c.aluOp = aluNor;
                    6'h2a: c.aluOp = aluSlt;
                    6'h2b: c.aluOp = aluSltu;
                    6'h00: c.aluOp = aluSll;
                    6'h02: c.aluOp = aluSrl;
                    6'h03: c.aluOp = aluSra;
                    // jr writes nothing
                    6'h08: begin
                        c.regWrite = 1'b0;
                        c.jumpReg = 1'b1;
                    end
                    6'h09: begin
                        c.jumpReg = 1'b1;
                        c.link = 1'b1;
                    end
                    default: begin
                        c.regWrite = 1'b0;
                        c.illegal = 1'b1;
                    end
                endcase
            end
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                c.regWrite = 1'b1;
                c.aluSrc = 1'b1;
                case (op)
                    6'h09: c.aluOp = aluAddu;
                    6'h0a: c.aluOp = aluSlt;
                    6'h0b: c.aluOp = aluSltu;
                    6'h0c: c.aluOp = aluAnd;
                    6'h0d: c.aluOp = aluOr;
                    6'h0e: c.aluOp = aluXor;
                    6'h0f: c.aluOp = aluLui;
                    default: c.aluOp = aluAdd;
                endcase
            end
            // lw
            6'h23: begin
                c.regWrite = 1'b1;
                c.aluSrc = 1'b1;
                c.memRead = 1'b1;
                c.memToReg = 1'b1;
            end
            // sw
            6'h2b: begin
                c.aluSrc = 1'b1;
                c.memWrite = 1'b1;
            end
            6'h04: c.branch = (rsVal == rtVal);
            6'h05: c.branch = (rsVal != rtVal);
            // blez and bgtz need rt = $0
            6'h06: begin
                c.illegal = (word[20:16] != 5'd0);
                c.branch = !c.illegal && ($signed(rsVal) <= 0);
            end
            6'h07: begin
                c.illegal = (word[20:16] != 5'd0);
                c.branch = !c.illegal && ($signed(rsVal) > 0);
            end
            6'h02: c.jump = 1'b1;
            6'h03: begin
                c.jump = 1'b1;
                c.link = 1'b1;
                c.regWrite = 1'b1;
                c.regDst = dstRa;
            end
            default: c.illegal = 1'b1;
        endcase
        return c;
    endfunction

    // write lands on the next edge, model follows
    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        wb = '{enable: 1'b1, addr: addr, data: data};
        waitCycles(1);
        wb.enable = 1'b0;
        if (addr != 5'd0) begin
            model[addr] = data;
        end
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic testResetState();
        for (int r = 0; r < 32; r++) begin
            instr = rType(5'(r), 5'(31 - r), 5'd0, 6'h20);
            settle();
            checkWord($sformatf("readData1 r%0d after reset", r), 32'd0, dec.readData1);
            checkWord($sformatf("readData2 r%0d after reset", 31 - r), 32'd0, dec.readData2);
            waitCycles(1);
        end
    endtask

    task automatic testRegisterFile();
        for (int r = 1; r < 32; r++) begin
            writeReg(5'(r), $urandom());
        end
        // stride 7 pairs each register with a different partner
        for (int r = 0; r < 32; r++) begin
            instr = rType(5'(r), 5'((r * 7) % 32), 5'd0, 6'h21);
            settle();
            checkWord($sformatf("readData1 r%0d", r), model[r], dec.readData1);
            checkWord($sformatf("readData2 r%0d", (r * 7) % 32), model[(r * 7) % 32],
                      dec.readData2);
            waitCycles(1);
        end
        writeReg(5'd0, 32'hdead_beef);
        instr = rType(5'd0, 5'd0, 5'd0, 6'h20);
        settle();
        checkWord("readData1 r0 after write", 32'd0, dec.readData1);
        checkWord("readData2 r0 after write", 32'd0, dec.readData2);
        waitCycles(1);
    endtask

    task automatic testBypass();
        logic [31:0] value;
        value = $urandom();
        instr = rType(5'd5, 5'd9, 5'd0, 6'h21);
        wb = '{enable: 1'b1, addr: 5'd5, data: value};
        settle();
        checkWord("bypass readData1 r5", value, dec.readData1);
        checkWord("readData2 r9 beside bypass", model[9], dec.readData2);
        waitCycles(1);
        wb.enable = 1'b0;
        model[5] = value;
        settle();
        checkWord("readData1 r5 after commit", value, dec.readData1);
        // port 2, then $0 never forwarded
        value = $urandom();
        instr = rType(5'd0, 5'd12, 5'd0, 6'h21);
        wb = '{enable: 1'b1, addr: 5'd12, data: value};
        settle();
        checkWord("bypass readData2 r12", value, dec.readData2);
        wb.addr = 5'd0;
        settle();
        checkWord("readData1 r0 during write to r0", 32'd0, dec.readData1);
        waitCycles(1);
        wb.enable = 1'b0;
    endtask

    task automatic testControlDecode();
        logic [31:0] word;
        for (int op = 0; op < 64; op++) begin
            word = {6'(op), 26'($urandom())};
            instr = word;
            settle();
            checkCtrl($sformatf("ctrl for %h", word),
                      expectedCtrl(word, model[word[25:21]], model[word[20:16]]), ctrl);
            waitCycles(1);
        end
        for (int fn = 0; fn < 64; fn++) begin
            word = {6'h00, 20'($urandom()), 6'(fn)};
            instr = word;
            settle();
            checkCtrl($sformatf("ctrl for %h", word),
                      expectedCtrl(word, model[word[25:21]], model[word[20:16]]), ctrl);
            waitCycles(1);
        end
    endtask

    task automatic branchCase(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
                              input bit taken);
        logic [31:0] word;
        word = iType(op, rs, rt, 16'h0010);
        instr = word;
        settle();
        checkWord($sformatf("ctrl.branch op %h rs r%0d rt r%0d", op, rs, rt),
                  {31'd0, taken}, {31'd0, ctrl.branch});
        checkCtrl($sformatf("ctrl for %h", word), expectedCtrl(word, model[rs], model[rt]), ctrl);
        waitCycles(1);
    endtask

    task automatic testBranches();
        writeReg(5'd1, 32'd5);
        writeReg(5'd2, 32'd5);
        writeReg(5'd3, 32'd7);
        writeReg(5'd4, 32'hffff_fffd);
        writeReg(5'd6, 32'h8000_0000);
        writeReg(5'd7, 32'h7fff_ffff);
        // beq
        branchCase(6'h04, 5'd1, 5'd2, 1'b1);
        branchCase(6'h04, 5'd1, 5'd3, 1'b0);
        branchCase(6'h04, 5'd0, 5'd0, 1'b1);
        // bne
        branchCase(6'h05, 5'd1, 5'd2, 1'b0);
        branchCase(6'h05, 5'd1, 5'd3, 1'b1);
        branchCase(6'h05, 5'd3, 5'd4, 1'b1);
        // blez, last one has rt nonzero
        branchCase(6'h06, 5'd4, 5'd0, 1'b1);
        branchCase(6'h06, 5'd0, 5'd0, 1'b1);
        branchCase(6'h06, 5'd1, 5'd0, 1'b0);
        branchCase(6'h06, 5'd6, 5'd0, 1'b1);
        branchCase(6'h06, 5'd4, 5'd1, 1'b0);
        // bgtz
        branchCase(6'h07, 5'd1, 5'd0, 1'b1);
        branchCase(6'h07, 5'd0, 5'd0, 1'b0);
        branchCase(6'h07, 5'd4, 5'd0, 1'b0);
        branchCase(6'h07, 5'd7, 5'd0, 1'b1);
        branchCase(6'h07, 5'd6, 5'd0, 1'b0);
    endtask

    task automatic testFields();
        logic [31:0] word;
        logic [31:0] pc;
        logic [31:0] ext;
        decodeOutT   expected;
        for (int i = 0; i < 64; i++) begin
            word = $urandom();
            pc = $urandom();
            instr = word;
            pcPlus4 = pc;
            settle();
            ext = {{16{word[15]}}, word[15:0]};
            expected.readData1 = model[word[25:21]];
            expected.readData2 = model[word[20:16]];
            expected.pcPlus4 = pc;
            expected.signExtImm = ext;
            expected.branchTarget = pc + ext * 32'd4;
            expected.jumpTarget = {pc[31:28], word[25:0], 2'b00};
            expected.rt = word[20:16];
            expected.rd = word[15:11];
            expected.shamt = word[10:6];
            expected.funct = word[5:0];
            checkDec($sformatf("dec for %h at pc+4 %h", word, pc), expected, dec);
            waitCycles(1);
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        void'($urandom(32'hd925));
        Clk = 1'b0;
        rstN = 1'b0;
        instr = '0;
        pcPlus4 = '0;
        wb = '0;
        cycleCount = 0;
        errorCount = 0;
        checkCount = 0;
        timedOut = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        waitCycles(3);
        rstN = 1'b1;

        testResetState();
        testRegisterFile();
        testBypass();
        testControlDecode();
        testBranches();
        testFields();

        $display("checks %0d, errors %0d, timeout %0d", checkCount, errorCount, timedOut);
        if (errorCount == 0 && !timedOut) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
hw/decodePkg.sv
hw/registerFile.sv
hw/decodeController.sv
hw/instructionDecodeStage.sv
dv/decodeStageAsserts.sv
dv/tbDecodeStage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tbDecodeStage --Mdir "$BUILD_DIR" -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/VtbDecodeStage" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG_FILE"; then
    exit 0
fi
exit 1
